//--- sources.f
common/mem_pkg.sv
hdl/lsu_agu.sv
store_buffer/sb_occupancy_counter.sv
store_buffer/store_buffer.sv
hdl/load_ctrl_fsm.sv
hdl/data_ram.sv
hdl/mem_subsystem.sv
testbench/mem_subsystem_assertions.sv
testbench/tb_mem_subsystem.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - common/mem_pkg.sv
      - hdl/lsu_agu.sv
      - store_buffer/sb_occupancy_counter.sv
      - store_buffer/store_buffer.sv
      - hdl/load_ctrl_fsm.sv
      - hdl/data_ram.sv
      - hdl/mem_subsystem.sv
  - target: test
    files:
      - testbench/mem_subsystem_assertions.sv
      - testbench/tb_mem_subsystem.sv

//--- testbench/tb_mem_subsystem.sv
/*
  Testbench for the load/store subsystem
  - clock, reset, directed and random stimulus on falling edges
  - byte reference memory with a queue of uncommitted stores
  - in-order compare of load writeback, store completion and exceptions
*/
`timescale 1ns/1ps

module tb_mem_subsystem;
  import mem_pkg::*;

  localparam int N_RANDOM    = 200;
  localparam int N_OPS       = N_RANDOM + 60;
  localparam int CYCLE_LIMIT = 20 * N_OPS + 200;

  logic      cpu_clk_i;
  logic      rst_n_i;
  logic      issue_vld_i;
  mem_op_e   issue_op_i;
  word_t     issue_base_i;
  word_t     issue_imm_i;
  word_t     issue_sdata_i;
  rob_id_t   issue_rob_i;
  preg_t     issue_dest_i;
  logic      commit_i;
  logic      flush_i;
  logic      busy_o;
  logic      st_cmp_valid_o;
  rob_id_t   st_cmp_rob_o;
  logic      ld_cmp_valid_o;
  rob_id_t   ld_cmp_rob_o;
  logic      rf_we_o;
  preg_t     rf_dest_o;
  word_t     rf_data_o;
  logic      exception_o;
  rob_id_t   exception_rob_o;
  exc_code_e exception_code_o;
  logic      sb_empty_o;

  int        seed = 32'hd06f;
  int        cyc = 0;
  rob_id_t   next_rob = '0;

  // Committed memory of the 64-byte window and the uncommitted stores
  logic [7:0] mem_ref [64];
  int         pq_word [$];
  mask_t      pq_mask [$];
  word_t      pq_data [$];

  // Expectations, in issue order per kind
  word_t     ld_data_q [$];
  preg_t     ld_dest_q [$];
  rob_id_t   ld_rob_q [$];
  int        ld_edge_q [$];
  int        ld_lat_q [$];
  rob_id_t   st_rob_q [$];
  int        st_edge_q [$];
  exc_code_e exc_code_q [$];
  rob_id_t   exc_rob_q [$];

  mem_subsystem mem_subsystem_i (.*);

  initial begin
    cpu_clk_i = 1'b0;
    forever #5 cpu_clk_i = ~cpu_clk_i;
  end

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED t=%0t %s got %h expected %h",
                                  $time, name, got, exp));
    end
  endtask

  task automatic check_rob(string name, rob_id_t got, rob_id_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED t=%0t %s got %h expected %h",
                                  $time, name, got, exp));
    end
  endtask

  task automatic check_preg(string name, preg_t got, preg_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED t=%0t %s got %h expected %h",
                                  $time, name, got, exp));
    end
  endtask

  task automatic check_exc(string name, exc_code_e got, exc_code_e exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED t=%0t %s got %0d expected %0d",
                                  $time, name, got, exp));
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("CHECK FAILED t=%0t %s got %b expected %b",
                                  $time, name, got, exp));
    end
  endtask

  task automatic check_cycles(string name, int got, int exp);
    if (got != exp) begin
      stop_with_failure($sformatf("CHECK FAILED t=%0t %s got %0d expected %0d",
                                  $time, name, got, exp));
    end
  endtask

  // Committed bytes with pending stores laid over them, oldest first
  function automatic word_t ref_load(word_t addr, mem_op_e op);
    logic [7:0] b [4];
    word_t      w;
    word_t      s;
    int         wi;
    wi = addr[5:2];
    for (int i = 0; i < 4; i++) b[i] = mem_ref[wi * 4 + i];
    for (int k = 0; k < pq_word.size(); k++) begin
      if (pq_word[k] == wi) begin
        for (int i = 0; i < 4; i++) begin
          if (pq_mask[k][i]) b[i] = pq_data[k][8*i +: 8];
        end
      end
    end
    w = {b[3], b[2], b[1], b[0]};
    s = w >> (8 * addr[1:0]);
    case (op)
      OP_LB:   return {{24{s[7]}}, s[7:0]};
      OP_LBU:  return {24'h0, s[7:0]};
      OP_LH:   return {{16{s[15]}}, s[15:0]};
      OP_LHU:  return {16'h0, s[15:0]};
      default: return w;
    endcase
  endfunction

  task automatic commit_pulse();
    commit_i = 1'b1;
    for (int i = 0; i < 4; i++) begin
      if (pq_mask[0][i]) mem_ref[pq_word[0] * 4 + i] = pq_data[0][8*i +: 8];
    end
    void'(pq_word.pop_front());
    void'(pq_mask.pop_front());
    void'(pq_data.pop_front());
    @(negedge cpu_clk_i);
    commit_i = 1'b0;
  endtask

  // A load in flight finishes within two cycles on its own
  // A stalled load or a full buffer only clears once stores are committed
  task automatic wait_ready();
    int waited;
    waited = 0;
    while (busy_o) begin
      if (waited >= 2 && pq_word.size() > 0) begin
        commit_pulse();
      end else begin
        waited++;
        @(negedge cpu_clk_i);
      end
    end
  endtask

  task automatic wait_empty();
    while (!sb_empty_o) @(negedge cpu_clk_i);
  endtask

  task automatic flush_pulse();
    wait_ready();
    flush_i = 1'b1;
    pq_word.delete();
    pq_mask.delete();
    pq_data.delete();
    @(negedge cpu_clk_i);
    flush_i = 1'b0;
  endtask

  // lat 0 leaves the load latency unchecked
  task automatic issue(mem_op_e op, word_t base, word_t imm, word_t sdata, int lat);
    word_t addr;
    int    sz;
    mask_t m;
    logic  mis;
    logic  is_ld;
    preg_t dest;
    wait_ready();
    addr  = base + imm;
    is_ld = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    sz    = (op inside {OP_LW, OP_SW}) ? 4 : (op inside {OP_LH, OP_LHU, OP_SH}) ? 2 : 1;
    m     = mask_t'(((1 << sz) - 1) << addr[1:0]);
    mis   = (addr % sz) != 0;
    dest  = preg_t'($random(seed));
    issue_vld_i   = 1'b1;
    issue_op_i    = op;
    issue_base_i  = base;
    issue_imm_i   = imm;
    issue_sdata_i = sdata;
    issue_rob_i   = next_rob;
    issue_dest_i  = dest;
    if (mis || addr >= 32'd1024) begin
      exc_code_q.push_back(mis ? (is_ld ? EXC_LD_MISALIGN : EXC_ST_MISALIGN)
                               : (is_ld ? EXC_LD_FAULT : EXC_ST_FAULT));
      exc_rob_q.push_back(next_rob);
    end else if (is_ld) begin
      ld_data_q.push_back(ref_load(addr, op));
      ld_dest_q.push_back(dest);
      ld_rob_q.push_back(next_rob);
      ld_edge_q.push_back(cyc + 1);
      ld_lat_q.push_back(lat);
    end else begin
      pq_word.push_back(addr[5:2]);
      pq_mask.push_back(m);
      pq_data.push_back(sdata << (8 * addr[1:0]));
      st_rob_q.push_back(next_rob);
      st_edge_q.push_back(cyc + 1);
    end
    next_rob++;
    @(negedge cpu_clk_i);
    issue_vld_i = 1'b0;
    @(negedge cpu_clk_i);
  endtask

  always @(posedge cpu_clk_i) begin
    if (rst_n_i) begin
      cyc++;
      if (cyc > CYCLE_LIMIT) stop_with_failure("Run exceeded its cycle limit");
      if (mem_subsystem_i.mem_subsystem_assertions_i.fail_count != 0) begin
        stop_with_failure("A bound assertion on the DUT failed");
      end
      if (rf_we_o) begin
        if (ld_data_q.size() == 0) stop_with_failure("Load writeback with no load pending");
        check_word("rf_data_o", rf_data_o, ld_data_q.pop_front());
        check_preg("rf_dest_o", rf_dest_o, ld_dest_q.pop_front());
        check_rob("ld_cmp_rob_o", ld_cmp_rob_o, ld_rob_q.pop_front());
        if (ld_lat_q[0] != 0) check_cycles("load latency", cyc - ld_edge_q[0], ld_lat_q[0]);
        void'(ld_edge_q.pop_front());
        void'(ld_lat_q.pop_front());
      end
      if (st_cmp_valid_o) begin
        if (st_rob_q.size() == 0) stop_with_failure("Store completion with no store pending");
        check_rob("st_cmp_rob_o", st_cmp_rob_o, st_rob_q.pop_front());
        check_cycles("store latency", cyc - st_edge_q.pop_front(), 1);
      end
      if (exception_o) begin
        if (exc_rob_q.size() == 0) stop_with_failure("Exception with no faulting operation");
        check_exc("exception_code_o", exception_code_o, exc_code_q.pop_front());
        check_rob("exception_rob_o", exception_rob_o, exc_rob_q.pop_front());
      end
    end
  end

  initial begin
    int      r;
    int      wi;
    int      off;
    mem_op_e op;
    rst_n_i       = 1'b0;
    issue_vld_i   = 1'b0;
    issue_op_i    = OP_LW;
    issue_base_i  = '0;
    issue_imm_i   = '0;
    issue_sdata_i = '0;
    issue_rob_i   = '0;
    issue_dest_i  = '0;
    commit_i      = 1'b0;
    flush_i       = 1'b0;
    repeat (8) @(negedge cpu_clk_i);
    rst_n_i = 1'b1;
    @(negedge cpu_clk_i);

    // Fill the window so every later load has known data
    for (int i = 0; i < 16; i++) issue(OP_SW, 32'h0, 4 * i, $random(seed), 0);
    while (pq_word.size() > 0) commit_pulse();
    wait_empty();

    // Committed store read back from the RAM
    issue(OP_SW, 32'h10, 32'h0, 32'hcafe_1234, 0);
    commit_pulse();
    wait_empty();
    issue(OP_LW, 32'h0, 32'h10, 32'h0, 3);

    // Forwarding from an uncommitted covering store
    issue(OP_SW, 32'h14, 32'h0, 32'h1357_9bdf, 0);
    issue(OP_LW, 32'h14, 32'h0, 32'h0, 2);
    issue(OP_LHU, 32'h14, 32'h2, 32'h0, 2);

    // Partial overlap stalls until the byte store drains
    issue(OP_SB, 32'h18, 32'h1, 32'h0000_00a5, 0);
    issue(OP_LW, 32'h18, 32'h0, 32'h0, 0);
    wait_ready();

    // Extension of bytes and halves
    issue(OP_SW, 32'h20, 32'h0, 32'h80f0_8f7f, 0);
    while (pq_word.size() > 0) commit_pulse();
    wait_empty();
    for (int o = 0; o < 4; o++) begin
      issue(OP_LB, 32'h20, o, 32'h0, 3);
      issue(OP_LBU, 32'h20, o, 32'h0, 3);
    end
    issue(OP_LH, 32'h20, 32'h2, 32'h0, 3);
    issue(OP_LHU, 32'h20, 32'h2, 32'h0, 3);
    issue(OP_LH, 32'h20, 32'h0, 32'h0, 3);

    // Faults leave memory untouched, also the word an out-of-range store aliases
    issue(OP_LW, 32'h20, 32'h2, 32'h0, 0);
    issue(OP_LW, 32'h400, 32'h0, 32'h0, 0);
    issue(OP_SH, 32'h20, 32'h1, 32'hffff_ffff, 0);
    issue(OP_SB, 32'h400, 32'h4, 32'hffff_ffff, 0);
    issue(OP_LW, 32'h20, 32'h0, 32'h0, 3);
    issue(OP_LW, 32'h4, 32'h0, 32'h0, 3);

    // Flush drops uncommitted stores only
    issue(OP_SW, 32'h34, 32'h0, 32'h1111_2222, 0);
    commit_pulse();
    issue(OP_SW, 32'h30, 32'h0, 32'hdead_beef, 0);
    check_flag("sb_empty_o", sb_empty_o, 1'b0);
    flush_pulse();
    check_flag("sb_empty_o", sb_empty_o, 1'b1);
    issue(OP_LW, 32'h30, 32'h0, 32'h0, 3);
    issue(OP_LW, 32'h34, 32'h0, 32'h0, 3);

    for (int n = 0; n < N_RANDOM; n++) begin
      r   = $unsigned($random(seed)) % 16;
      wi  = $unsigned($random(seed)) % 16;
      off = $unsigned($random(seed)) % 4;
      if (r < 6) begin
        op = mem_op_e'(5 + off % 3);
        if (op == OP_SW) off = 0;
        if (op == OP_SH) off = off & 2;
        issue(op, 4 * wi, off, $random(seed), 0);
      end else if (r < 12) begin
        op = mem_op_e'(($unsigned($random(seed))) % 5);
        if (op == OP_LW) off = 0;
        if (op inside {OP_LH, OP_LHU}) off = off & 2;
        issue(op, 4 * wi, off, 32'h0, 0);
      end else if (r < 14) begin
        if (pq_word.size() > 0) commit_pulse();
      end else if (r == 14) begin
        flush_pulse();
      end else begin
        issue(mem_op_e'(($unsigned($random(seed))) % 8), 32'h400, 4 * wi + off,
              $random(seed), 0);
      end
    end

    wait_ready();
    while (pq_word.size() > 0) commit_pulse();
    wait_empty();
    repeat (5) @(negedge cpu_clk_i);
    if (ld_data_q.size() == 0 && st_rob_q.size() == 0 && exc_rob_q.size() == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Expected results never arrived from the DUT");
      $display("*** FAILED ***");
      $fatal(1);
    end
  end

endmodule

//--- testbench/mem_subsystem_assertions.sv
/*
  Bound checks on the load/store subsystem top level
  - no operation accepted while busy
  - store buffer empty out of reset
  - load writeback and load completion together
  - exception never together with store completion
  - count of failed checks
*/
`timescale 1ns/1ps

module mem_subsystem_assertions (
  input logic cpu_clk_i,
  input logic rst_n_i,
  input logic issue_vld_i,
  input logic busy_o,
  input logic sb_empty_o,
  input logic rf_we_o,
  input logic ld_cmp_valid_o,
  input logic exception_o,
  input logic st_cmp_valid_o
);

  int unsigned fail_count = 0;

  no_issue_when_busy: assert property (
    @(posedge cpu_clk_i) disable iff (!rst_n_i) !(issue_vld_i && busy_o)
  ) else begin
    $error("issue strobe seen while busy_o is high");
    fail_count++;
  end

  empty_after_reset: assert property (
    @(posedge cpu_clk_i) $rose(rst_n_i) |-> sb_empty_o
  ) else begin
    $error("store buffer not empty after reset");
    fail_count++;
  end

  writeback_with_completion: assert property (
    @(posedge cpu_clk_i) disable iff (!rst_n_i) rf_we_o == ld_cmp_valid_o
  ) else begin
    $error("rf_we_o and ld_cmp_valid_o differ");
    fail_count++;
  end

  exception_not_with_store: assert property (
    @(posedge cpu_clk_i) disable iff (!rst_n_i) !(exception_o && st_cmp_valid_o)
  ) else begin
    $error("exception_o and st_cmp_valid_o high together");
    fail_count++;
  end

endmodule

bind mem_subsystem mem_subsystem_assertions mem_subsystem_assertions_i (.*);

//--- hdl/mem_subsystem.sv
/*
  Load/store subsystem top level
  - AGU stage, store buffer with its occupancy counter
  - load sequencer and data RAM
  - store completion and exception taken from the AGU stage
*/
`timescale 1ns/1ps

module mem_subsystem #(
  parameter int SB_ENTRIES = 8,
  parameter int RAM_WORDS  = 256
) (
  input  logic               cpu_clk_i,
  input  logic               rst_n_i,
  input  logic               issue_vld_i,
  input  mem_pkg::mem_op_e   issue_op_i,
  input  mem_pkg::word_t     issue_base_i,
  input  mem_pkg::word_t     issue_imm_i,
  input  mem_pkg::word_t     issue_sdata_i,
  input  mem_pkg::rob_id_t   issue_rob_i,
  input  mem_pkg::preg_t     issue_dest_i,
  input  logic               commit_i,
  input  logic               flush_i,
  output logic               busy_o,
  output logic               st_cmp_valid_o,
  output mem_pkg::rob_id_t   st_cmp_rob_o,
  output logic               ld_cmp_valid_o,
  output mem_pkg::rob_id_t   ld_cmp_rob_o,
  output logic               rf_we_o,
  output mem_pkg::preg_t     rf_dest_o,
  output mem_pkg::word_t     rf_data_o,
  output logic               exception_o,
  output mem_pkg::rob_id_t   exception_rob_o,
  output mem_pkg::exc_code_e exception_code_o,
  output logic               sb_empty_o
);
  import mem_pkg::*;

  localparam int PTR_W = $clog2(SB_ENTRIES) + 1;

  logic       agu_vld;
  mem_op_e    agu_op;
  word_t      agu_addr;
  mask_t      agu_mask;
  word_t      agu_data;
  rob_id_t    agu_rob;
  preg_t      agu_dest;
  logic       agu_exc;
  exc_code_e  agu_exc_code;

  logic             sb_enq;
  logic             sb_drain;
  logic             sb_full;
  logic [PTR_W-1:0] sb_head;
  logic [PTR_W-1:0] sb_tail;
  fwd_e             fwd;
  word_t            fwd_data;
  word_t            fwd_addr;
  mask_t            fwd_mask;

  logic        ram_we;
  logic [29:0] ram_waddr;
  mask_t       ram_wmask;
  word_t       ram_wdata;
  logic        ram_re;
  logic [29:0] ram_raddr;
  word_t       ram_rdata;

  lsu_agu #(
    .RAM_WORDS(RAM_WORDS)
  ) lsu_agu_i (
    .cpu_clk_i     (cpu_clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .issue_vld_i   (issue_vld_i),
    .issue_op_i    (issue_op_i),
    .issue_base_i  (issue_base_i),
    .issue_imm_i   (issue_imm_i),
    .issue_sdata_i (issue_sdata_i),
    .issue_rob_i   (issue_rob_i),
    .issue_dest_i  (issue_dest_i),
    .busy_i        (busy_o),
    .agu_vld_o     (agu_vld),
    .agu_op_o      (agu_op),
    .agu_addr_o    (agu_addr),
    .agu_mask_o    (agu_mask),
    .agu_data_o    (agu_data),
    .agu_rob_o     (agu_rob),
    .agu_dest_o    (agu_dest),
    .agu_exc_o     (agu_exc),
    .agu_exc_code_o(agu_exc_code)
  );

  // Good stores complete as they enter the buffer
  assign sb_enq           = agu_vld & ~agu_exc & ~op_is_load(agu_op) & ~flush_i;
  assign st_cmp_valid_o   = sb_enq;
  assign st_cmp_rob_o     = agu_rob;
  assign exception_o      = agu_vld & agu_exc & ~flush_i;
  assign exception_rob_o  = agu_rob;
  assign exception_code_o = agu_exc_code;

  sb_occupancy_counter #(
    .SB_ENTRIES(SB_ENTRIES)
  ) sb_occupancy_counter_i (
    .cpu_clk_i  (cpu_clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .enq_i      (sb_enq),
    .commit_i   (commit_i),
    .drain_o    (sb_drain),
    .head_o     (sb_head),
    .tail_o     (sb_tail),
    .committed_o(),
    .full_o     (sb_full),
    .empty_o    (sb_empty_o)
  );

  store_buffer #(
    .SB_ENTRIES(SB_ENTRIES)
  ) store_buffer_i (
    .cpu_clk_i (cpu_clk_i),
    .rst_n_i   (rst_n_i),
    .enq_i     (sb_enq),
    .enq_addr_i(agu_addr),
    .enq_mask_i(agu_mask),
    .enq_data_i(agu_data),
    .drain_i   (sb_drain),
    .head_i    (sb_head),
    .tail_i    (sb_tail),
    .fwd_addr_i(fwd_addr),
    .fwd_mask_i(fwd_mask),
    .fwd_o     (fwd),
    .fwd_data_o(fwd_data),
    .ram_we_o  (ram_we),
    .ram_addr_o(ram_waddr),
    .ram_mask_o(ram_wmask),
    .ram_data_o(ram_wdata)
  );

  load_ctrl_fsm load_ctrl_fsm_i (
    .cpu_clk_i     (cpu_clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .agu_vld_i     (agu_vld),
    .agu_op_i      (agu_op),
    .agu_addr_i    (agu_addr),
    .agu_mask_i    (agu_mask),
    .agu_rob_i     (agu_rob),
    .agu_dest_i    (agu_dest),
    .agu_exc_i     (agu_exc),
    .sb_full_i     (sb_full),
    .fwd_i         (fwd),
    .fwd_data_i    (fwd_data),
    .ram_rdata_i   (ram_rdata),
    .busy_o        (busy_o),
    .fwd_addr_o    (fwd_addr),
    .fwd_mask_o    (fwd_mask),
    .ram_re_o      (ram_re),
    .ram_raddr_o   (ram_raddr),
    .rf_we_o       (rf_we_o),
    .rf_dest_o     (rf_dest_o),
    .rf_data_o     (rf_data_o),
    .ld_cmp_valid_o(ld_cmp_valid_o),
    .ld_cmp_rob_o  (ld_cmp_rob_o)
  );

  data_ram #(
    .RAM_WORDS(RAM_WORDS)
  ) data_ram_i (
    .cpu_clk_i(cpu_clk_i),
    .we_i     (ram_we),
    .waddr_i  (ram_waddr),
    .wmask_i  (ram_wmask),
    .wdata_i  (ram_wdata),
    .re_i     (ram_re),
    .raddr_i  (ram_raddr),
    .rdata_o  (ram_rdata)
  );

endmodule

//--- hdl/data_ram.sv
/*
  Tightly coupled data RAM
  - word array with byte-masked write port
  - read port registered one cycle after the read strobe
*/
`timescale 1ns/1ps

module data_ram #(
  parameter  int RAM_WORDS = 256,
  localparam int AW        = $clog2(RAM_WORDS)
) (
  input  logic           cpu_clk_i,
  input  logic           we_i,
  input  logic [29:0]    waddr_i,
  input  mem_pkg::mask_t wmask_i,
  input  mem_pkg::word_t wdata_i,
  input  logic           re_i,
  input  logic [29:0]    raddr_i,
  output mem_pkg::word_t rdata_o
);
  import mem_pkg::*;

  word_t mem_q [RAM_WORDS];

  // Word addresses are range checked in the AGU, so low bits index the array
  always_ff @(posedge cpu_clk_i) begin
    if (we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (wmask_i[b]) begin
          mem_q[waddr_i[AW-1:0]][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
    if (re_i) begin
      rdata_o <= mem_q[raddr_i[AW-1:0]];
    end
  end

endmodule

//--- hdl/load_ctrl_fsm.sv
/*
  Load sequencer
  - takes one load from the AGU stage and holds it
  - store buffer search, stall on partial overlap, RAM read otherwise
  - issue back-pressure and register file writeback
*/
`timescale 1ns/1ps

module load_ctrl_fsm (
  input  logic             cpu_clk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,
  input  logic             agu_vld_i,
  input  mem_pkg::mem_op_e agu_op_i,
  input  mem_pkg::word_t   agu_addr_i,
  input  mem_pkg::mask_t   agu_mask_i,
  input  mem_pkg::rob_id_t agu_rob_i,
  input  mem_pkg::preg_t   agu_dest_i,
  input  logic             agu_exc_i,
  input  logic             sb_full_i,
  input  mem_pkg::fwd_e    fwd_i,
  input  mem_pkg::word_t   fwd_data_i,
  input  mem_pkg::word_t   ram_rdata_i,
  output logic             busy_o,
  output mem_pkg::word_t   fwd_addr_o,
  output mem_pkg::mask_t   fwd_mask_o,
  output logic             ram_re_o,
  output logic [29:0]      ram_raddr_o,
  output logic             rf_we_o,
  output mem_pkg::preg_t   rf_dest_o,
  output mem_pkg::word_t   rf_data_o,
  output logic             ld_cmp_valid_o,
  output mem_pkg::rob_id_t ld_cmp_rob_o
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    WAIT_DRAIN,
    RAM_READ
  } state_e;

  state_e  state_q;
  state_e  state_d;
  logic    agu_load;
  word_t   ld_src;
  mem_op_e ld_op_q;
  word_t   ld_addr_q;
  mask_t   ld_mask_q;
  rob_id_t ld_rob_q;
  preg_t   ld_dest_q;

  assign agu_load = agu_vld_i & op_is_load(agu_op_i);

  // Only one load in flight, so issue waits while one is queued or pending
  assign busy_o = (state_q != IDLE) | agu_load | sb_full_i;

  always_comb begin
    state_d  = state_q;
    ram_re_o = 1'b0;
    rf_we_o  = 1'b0;
    case (state_q)
      IDLE: begin
        if (agu_load && !agu_exc_i) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP, WAIT_DRAIN: begin
        case (fwd_i)
          FWD_HIT: begin
            rf_we_o = 1'b1;
            state_d = IDLE;
          end
          FWD_STALL: state_d = WAIT_DRAIN;
          default: begin
            ram_re_o = 1'b1;
            state_d  = RAM_READ;
          end
        endcase
      end
      RAM_READ: begin
        rf_we_o = 1'b1;
        state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
    if (flush_i) begin
      state_d  = IDLE;
      ram_re_o = 1'b0;
      rf_we_o  = 1'b0;
    end
  end

  always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge cpu_clk_i) begin
    if (state_q == IDLE && agu_load) begin
      ld_op_q   <= agu_op_i;
      ld_addr_q <= agu_addr_i;
      ld_mask_q <= agu_mask_i;
      ld_rob_q  <= agu_rob_i;
      ld_dest_q <= agu_dest_i;
    end
  end

  assign fwd_addr_o  = ld_addr_q;
  assign fwd_mask_o  = ld_mask_q;
  assign ram_raddr_o = ld_addr_q[31:2];

  // Forwarded word in the search cycle, registered RAM word after a read
  assign ld_src         = (state_q == RAM_READ) ? ram_rdata_i : fwd_data_i;
  assign rf_data_o      = load_extend(ld_src, ld_addr_q[1:0], ld_op_q);
  assign rf_dest_o      = ld_dest_q;
  assign ld_cmp_valid_o = rf_we_o;
  assign ld_cmp_rob_o   = ld_rob_q;

endmodule

//--- store_buffer/store_buffer.sv
/*
  Store buffer entry array
  - enqueue at the tail, drain of the head entry into the data RAM
  - valid bits trimmed to the live head..tail window after a flush
  - combinational forwarding search, youngest entry first
*/
`timescale 1ns/1ps

module store_buffer #(
  parameter  int SB_ENTRIES = 8,
  localparam int IDX_W      = $clog2(SB_ENTRIES),
  localparam int PTR_W      = IDX_W + 1
) (
  input  logic             cpu_clk_i,
  input  logic             rst_n_i,
  input  logic             enq_i,
  input  mem_pkg::word_t   enq_addr_i,
  input  mem_pkg::mask_t   enq_mask_i,
  input  mem_pkg::word_t   enq_data_i,
  input  logic             drain_i,
  input  logic [PTR_W-1:0] head_i,
  input  logic [PTR_W-1:0] tail_i,
  input  mem_pkg::word_t   fwd_addr_i,
  input  mem_pkg::mask_t   fwd_mask_i,
  output mem_pkg::fwd_e    fwd_o,
  output mem_pkg::word_t   fwd_data_o,
  output logic             ram_we_o,
  output logic [29:0]      ram_addr_o,
  output mem_pkg::mask_t   ram_mask_o,
  output mem_pkg::word_t   ram_data_o
);
  import mem_pkg::*;

  logic [29:0]           addr_q [SB_ENTRIES];
  mask_t                 mask_q [SB_ENTRIES];
  word_t                 data_q [SB_ENTRIES];
  logic [SB_ENTRIES-1:0] vld_q;
  logic [SB_ENTRIES-1:0] live;
  logic [IDX_W-1:0]      head_idx;
  logic [IDX_W-1:0]      tail_idx;
  logic [PTR_W-1:0]      occupancy;

  assign head_idx  = head_i[IDX_W-1:0];
  assign tail_idx  = tail_i[IDX_W-1:0];
  assign occupancy = tail_i - head_i;

  // Slots between head and tail, which shrinks when a flush pulls the tail back
  always_comb begin
    logic [IDX_W-1:0] offset;
    for (int i = 0; i < SB_ENTRIES; i++) begin
      offset  = IDX_W'(i) - head_idx;
      live[i] = {1'b0, offset} < occupancy;
    end
  end

  always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vld_q <= '0;
    end else begin
      for (int i = 0; i < SB_ENTRIES; i++) begin
        if (enq_i && tail_idx == IDX_W'(i)) begin
          vld_q[i] <= 1'b1;
        end else if (drain_i && head_idx == IDX_W'(i)) begin
          vld_q[i] <= 1'b0;
        end else begin
          vld_q[i] <= vld_q[i] & live[i];
        end
      end
    end
  end

  always_ff @(posedge cpu_clk_i) begin
    if (enq_i) begin
      addr_q[tail_idx] <= enq_addr_i[31:2];
      mask_q[tail_idx] <= enq_mask_i;
      data_q[tail_idx] <= enq_data_i;
    end
  end

  // Head entry goes straight to the RAM write port
  assign ram_we_o   = drain_i;
  assign ram_addr_o = addr_q[head_idx];
  assign ram_mask_o = mask_q[head_idx];
  assign ram_data_o = data_q[head_idx];

  // First overlapping entry walking back from the tail decides the result
  always_comb begin
    logic             found;
    logic [IDX_W-1:0] idx;
    found      = 1'b0;
    fwd_o      = FWD_NONE;
    fwd_data_o = '0;
    for (int k = 0; k < SB_ENTRIES; k++) begin
      idx = tail_idx - IDX_W'(k + 1);
      if (!found && vld_q[idx] && addr_q[idx] == fwd_addr_i[31:2] &&
          |(mask_q[idx] & fwd_mask_i)) begin
        found      = 1'b1;
        fwd_data_o = data_q[idx];
        if ((mask_q[idx] & fwd_mask_i) == fwd_mask_i) begin
          fwd_o = FWD_HIT;
        end else begin
          fwd_o = FWD_STALL;
        end
      end
    end
  end

endmodule

//--- store_buffer/sb_occupancy_counter.sv
/*
  Store buffer occupancy
  - head pointer with wrap bit, tail derived from the total count
  - total and committed entry counts
  - drain request, full and empty flags
*/
`timescale 1ns/1ps

module sb_occupancy_counter #(
  parameter  int SB_ENTRIES = 8,
  localparam int PTR_W      = $clog2(SB_ENTRIES) + 1
) (
  input  logic             cpu_clk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,
  input  logic             enq_i,
  input  logic             commit_i,
  output logic             drain_o,
  output logic [PTR_W-1:0] head_o,
  output logic [PTR_W-1:0] tail_o,
  output logic [PTR_W-1:0] committed_o,
  output logic             full_o,
  output logic             empty_o
);
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] total_q;
  logic [PTR_W-1:0] total_d;
  logic [PTR_W-1:0] cmt_q;
  logic [PTR_W-1:0] cmt_d;

  // Committed stores leave one per cycle
  assign drain_o = cmt_q != '0;
  assign cmt_d   = cmt_q + PTR_W'(commit_i) - PTR_W'(drain_o);

  // Flush keeps only committed stores, counting this cycle's pop
  assign total_d = flush_i ? cmt_d : total_q + PTR_W'(enq_i) - PTR_W'(drain_o);

  always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q  <= '0;
      total_q <= '0;
      cmt_q   <= '0;
    end else begin
      head_q  <= head_q + PTR_W'(drain_o);
      total_q <= total_d;
      cmt_q   <= cmt_d;
    end
  end

  assign head_o      = head_q;
  assign tail_o      = head_q + total_q;
  assign committed_o = cmt_q;
  assign empty_o     = total_q == '0;

  // A store leaving the AGU this cycle already claims its slot
  assign full_o = (total_q == PTR_W'(SB_ENTRIES)) ||
                  (enq_i && total_q == PTR_W'(SB_ENTRIES - 1));

endmodule

//--- hdl/lsu_agu.sv
/*
  Address generation stage
  - effective address and byte mask from size and low address bits
  - store data shifted into its byte lanes
  - misaligned and out-of-range fault detection
  - one registered stage, loaded when the unit is not busy
*/
`timescale 1ns/1ps

module lsu_agu #(
  parameter int RAM_WORDS = 256
) (
  input  logic               cpu_clk_i,
  input  logic               rst_n_i,
  input  logic               flush_i,
  input  logic               issue_vld_i,
  input  mem_pkg::mem_op_e   issue_op_i,
  input  mem_pkg::word_t     issue_base_i,
  input  mem_pkg::word_t     issue_imm_i,
  input  mem_pkg::word_t     issue_sdata_i,
  input  mem_pkg::rob_id_t   issue_rob_i,
  input  mem_pkg::preg_t     issue_dest_i,
  input  logic               busy_i,
  output logic               agu_vld_o,
  output mem_pkg::mem_op_e   agu_op_o,
  output mem_pkg::word_t     agu_addr_o,
  output mem_pkg::mask_t     agu_mask_o,
  output mem_pkg::word_t     agu_data_o,
  output mem_pkg::rob_id_t   agu_rob_o,
  output mem_pkg::preg_t     agu_dest_o,
  output logic               agu_exc_o,
  output mem_pkg::exc_code_e agu_exc_code_o
);
  import mem_pkg::*;

  // First byte address past the end of the data RAM
  localparam word_t ADDR_LIMIT = word_t'(RAM_WORDS * 4);

  logic      accept;
  logic      is_load;
  word_t     addr;
  mask_t     mask;
  logic      misalign;
  logic      out_of_range;
  exc_code_e exc_code;

  assign accept       = issue_vld_i & ~busy_i;
  assign is_load      = op_is_load(issue_op_i);
  assign addr         = issue_base_i + issue_imm_i;
  assign out_of_range = addr >= ADDR_LIMIT;

  always_comb begin
    case (issue_op_i)
      OP_LB, OP_LBU, OP_SB: begin
        mask     = mask_t'(4'b0001 << addr[1:0]);
        misalign = 1'b0;
      end
      OP_LH, OP_LHU, OP_SH: begin
        mask     = mask_t'(4'b0011 << addr[1:0]);
        misalign = addr[0];
      end
      default: begin
        mask     = 4'b1111;
        misalign = |addr[1:0];
      end
    endcase
  end

  // Misalignment wins over a range fault
  always_comb begin
    if (misalign) begin
      exc_code = is_load ? EXC_LD_MISALIGN : EXC_ST_MISALIGN;
    end else begin
      exc_code = is_load ? EXC_LD_FAULT : EXC_ST_FAULT;
    end
  end

  always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      agu_vld_o <= 1'b0;
    end else begin
      agu_vld_o <= accept & ~flush_i;
    end
  end

  always_ff @(posedge cpu_clk_i) begin
    if (accept) begin
      agu_op_o       <= issue_op_i;
      agu_addr_o     <= addr;
      agu_mask_o     <= mask;
      agu_data_o     <= issue_sdata_i << {addr[1:0], 3'b000};
      agu_rob_o      <= issue_rob_i;
      agu_dest_o     <= issue_dest_i;
      agu_exc_o      <= misalign | out_of_range;
      agu_exc_code_o <= exc_code;
    end
  end

endmodule

//--- common/mem_pkg.sv
/*
  Shared definitions for the load/store unit
  - fixed widths and payload types
  - operation, forwarding and exception encodings
  - load classification and result formatting helpers
*/
package mem_pkg;

  // ROB id width is fixed by the core
  localparam int ROB_W = 5;

  typedef logic [ROB_W-1:0] rob_id_t;
  typedef logic [5:0]       preg_t;
  typedef logic [31:0]      word_t;
  typedef logic [3:0]       mask_t;

  typedef enum logic [2:0] {
    OP_LB, OP_LH, OP_LW, OP_LBU,
    OP_LHU, OP_SB, OP_SH, OP_SW
  } mem_op_e;

  typedef enum logic [1:0] {
    FWD_NONE, FWD_HIT, FWD_STALL
  } fwd_e;

  typedef enum logic [3:0] {
    EXC_LD_MISALIGN = 4'd4,
    EXC_LD_FAULT    = 4'd5,
    EXC_ST_MISALIGN = 4'd6,
    EXC_ST_FAULT    = 4'd7
  } exc_code_e;

  function automatic logic op_is_load(mem_op_e op);
    return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
  endfunction

  // Moves the addressed bytes down to bit 0 and extends them
  function automatic word_t load_extend(word_t data, logic [1:0] offset, mem_op_e op);
    word_t shifted;
    shifted = data >> {offset, 3'b000};
    case (op)
      OP_LB:   return {{24{shifted[7]}}, shifted[7:0]};
      OP_LH:   return {{16{shifted[15]}}, shifted[15:0]};
      OP_LBU:  return {24'b0, shifted[7:0]};
      OP_LHU:  return {16'b0, shifted[15:0]};
      default: return shifted;
    endcase
  endfunction

endpackage
